// File: Makefile
TOP = cl_hello_world_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cl_hello_world.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cl_hello_world.f
+incdir+.
cl_hello_world_pkg.sv
ocl_axil_slave.sv
hello_world_reg.sv
vled_shadow.sv
tick_counter.sv
cl_hello_world.sv
cl_hello_world_tb.sv

// File: cl_hello_world.sv
module cl_hello_world (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  // AXI-Lite slave port
  input  logic                          awvalid,
  input  cl_hello_world_pkg::axil_addr_t awaddr,
  output logic                          awready,
  input  logic                          wvalid,
  input  cl_hello_world_pkg::axil_data_t wdata,
  output logic                          wready,
  output logic                          bvalid,
  output cl_hello_world_pkg::axil_resp_t bresp,
  input  logic                          bready,
  input  logic                          arvalid,
  input  cl_hello_world_pkg::axil_addr_t araddr,
  output logic                          arready,
  output logic                          rvalid,
  output cl_hello_world_pkg::axil_data_t rdata,
  output cl_hello_world_pkg::axil_resp_t rresp,
  input  logic                          rready,
  // Virtual switches and LEDs
  input  cl_hello_world_pkg::led_vec_t   vdip,
  output cl_hello_world_pkg::led_vec_t   vled,
  // Counter controls and status
  input  logic                          cnt_enable,
  input  logic                          cnt_load,
  input  logic                          cnt_clear,
  input  cl_hello_world_pkg::tick_t      tick_value,
  input  cl_hello_world_pkg::count_t     cnt_load_value,
  input  cl_hello_world_pkg::count_t     cnt_watermark,
  output logic                          tick,
  output logic                          cnt_ge_watermark,
  output cl_hello_world_pkg::tick_t      tick_cnt,
  output cl_hello_world_pkg::count_t     cnt
);
  import cl_hello_world_pkg::*;

  axil_data_t hello_q;
  led_vec_t   vled_q;
  logic       reg_wr;
  axil_addr_t reg_wr_addr;
  axil_data_t reg_wr_data;

  // ------------------------------------------------------------
  // Register block
  // ------------------------------------------------------------
  ocl_axil_slave u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .hello_q         (hello_q),
    .vled_q          (vled_q),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data)
  );

  hello_world_reg u_hello (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .hello_q         (hello_q)
  );

  vled_shadow u_vled (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_q         (hello_q),
    .vdip            (vdip),
    .vled_q          (vled_q),
    .vled            (vled)
  );

  // ------------------------------------------------------------
  // Free-standing tick counter
  // ------------------------------------------------------------
  tick_counter u_counter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .cnt_enable       (cnt_enable),
    .cnt_load         (cnt_load),
    .cnt_clear        (cnt_clear),
    .tick_value       (tick_value),
    .cnt_load_value   (cnt_load_value),
    .cnt_watermark    (cnt_watermark),
    .tick             (tick),
    .cnt_ge_watermark (cnt_ge_watermark),
    .tick_cnt         (tick_cnt),
    .cnt              (cnt)
  );

endmodule

// File: cl_hello_world_consts.svh
`ifndef CL_HELLO_WORLD_CONSTS_SVH
`define CL_HELLO_WORLD_CONSTS_SVH

// Register map
`define HELLO_WORLD_REG_ADDR    32'h0000_0500
`define VLED_REG_ADDR           32'h0000_0504

// Returned for any address outside the map
`define UNIMPLEMENTED_REG_VALUE 32'hDEAD_DEAD

// AXI response codes
`define AXI_RESP_OKAY           2'b00

`endif

// File: cl_hello_world_pkg.sv
package cl_hello_world_pkg;

  // ------------------------------------------------------------
  // AXI-Lite widths
  // ------------------------------------------------------------
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  // Virtual LED and DIP switch vector
  typedef logic [15:0] led_vec_t;

  // Prescaler and main counter widths
  typedef logic [7:0]  tick_t;
  typedef logic [15:0] count_t;

  // ------------------------------------------------------------
  // Channel state machines
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_DECODE,
    RD_RESP
  } rd_state_t;

endpackage

// File: cl_hello_world_tb.sv
`include "cl_hello_world_consts.svh"

module cl_hello_world_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cl_hello_world_pkg::*;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_LED, OP_COUNT} op_kind_t;

  // LED entries keep the switch value in expected[31:16]
  // Counter entries carry {K, T} in addr and {watermark, load} in data
  // Their expected value packs {tick, tick_cnt, ge, cnt} from bit 25 down
  typedef struct packed {
    op_kind_t   kind;
    axil_addr_t addr;
    axil_data_t data;
    axil_data_t expected;
  } entry_t;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;
  led_vec_t   vdip;
  led_vec_t   vled;
  logic       cnt_enable;
  logic       cnt_load;
  logic       cnt_clear;
  tick_t      tick_value;
  count_t     cnt_load_value;
  count_t     cnt_watermark;
  logic       tick;
  logic       cnt_ge_watermark;
  tick_t      tick_cnt;
  count_t     cnt;

  entry_t stim[$];
  int     errors      = 0;
  int     run_len     = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 100000;

  cl_hello_world dut0 (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  always @(posedge clk_main_a0) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: table did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  // ------------------------------------------------------------
  // Reference helpers
  // ------------------------------------------------------------
  task automatic check_value(input axil_data_t actual, input axil_data_t expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic axil_data_t byte_reverse(input axil_data_t v);
    axil_data_t r;
    for (int i = 0; i < 4; i++)
      r[8*i +: 8] = v[8*(3-i) +: 8];
    return r;
  endfunction

  // One wrap per T+1 enabled updates over K-1 updates in the window
  function automatic axil_data_t count_expect(input tick_t t, input int k,
                                              input count_t l, input count_t w);
    count_t final_cnt;
    tick_t  final_tick;
    final_cnt  = l + count_t'((k - 1) / (int'(t) + 1));
    final_tick = tick_t'((k - 1) % (int'(t) + 1));
    return {6'b0, final_tick >= t, final_tick, final_cnt >= w, final_cnt};
  endfunction

  function automatic entry_t make_entry(input op_kind_t kind, input axil_addr_t addr,
                                        input axil_data_t data, input axil_data_t expected);
    entry_t e;
    e.kind     = kind;
    e.addr     = addr;
    e.data     = data;
    e.expected = expected;
    return e;
  endfunction

  task automatic add_count_run(input tick_t t, input int k, input count_t l, input count_t w);
    stim.push_back(make_entry(OP_COUNT, {8'h00, k[15:0], t}, {w, l}, count_expect(t, k, l, w)));
    run_len += k;
  endtask

  task automatic build_table();
    axil_data_t hello_model;
    axil_data_t d;
    led_vec_t   dip;
    hello_model = $urandom;
    stim.push_back(make_entry(OP_WRITE, `HELLO_WORLD_REG_ADDR, hello_model, '0));
    stim.push_back(make_entry(OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(hello_model)));
    stim.push_back(make_entry(OP_READ, `VLED_REG_ADDR, '0, {16'h0000, hello_model[15:0]}));
    stim.push_back(make_entry(OP_READ, 32'h0000_0508, '0, `UNIMPLEMENTED_REG_VALUE));
    // A write outside the map leaves both readbacks alone
    stim.push_back(make_entry(OP_WRITE, 32'h0000_0600, $urandom, '0));
    stim.push_back(make_entry(OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(hello_model)));
    stim.push_back(make_entry(OP_READ, `VLED_REG_ADDR, '0, {16'h0000, hello_model[15:0]}));
    stim.push_back(make_entry(OP_READ, 32'h0000_0000, '0, `UNIMPLEMENTED_REG_VALUE));
    for (int i = 0; i < 4; i++) begin
      d   = $urandom;
      dip = (i == 0) ? 16'hffff : led_vec_t'($urandom);
      stim.push_back(make_entry(OP_LED, `HELLO_WORLD_REG_ADDR, d, {dip, d[15:0] & dip}));
      stim.push_back(make_entry(OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(d)));
      stim.push_back(make_entry(OP_READ, `VLED_REG_ADDR, '0, {16'h0000, d[15:0]}));
    end
    add_count_run(8'd3, 20, 16'h0010, 16'h0014);
    add_count_run(8'd0, 9, 16'h0100, 16'h0200);
    // Main count rolls over 16 bits here
    add_count_run(8'd5, 30, 16'hfffe, 16'h0001);
    add_count_run(tick_t'($urandom_range(1, 6)), int'($urandom_range(10, 40)),
                  count_t'($urandom), count_t'($urandom));
  endtask

  // ------------------------------------------------------------
  // Bus and counter drivers
  // ------------------------------------------------------------
  task automatic write_access(input axil_addr_t addr, input axil_data_t data);
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    int   gap;
    aw_done = 1'b0;
    w_done  = 1'b0;
    gap     = int'($urandom_range(0, 3));
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    while (!(aw_done && w_done)) begin
      @(negedge clk_main_a0);
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge clk_main_a0);
      if (aw_hs) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end
    do begin
      @(negedge clk_main_a0);
    end while (!bvalid);
    // Back-pressure on the response
    repeat (gap) begin
      @(negedge clk_main_a0);
      check_value(32'(bvalid), 32'd1, "bvalid dropped while bready was low");
    end
    @(posedge clk_main_a0);
    bready <= 1'b1;
    @(negedge clk_main_a0);
    check_value(32'(bresp), 32'(`AXI_RESP_OKAY), "write response code");
    @(posedge clk_main_a0);
    bready <= 1'b0;
  endtask

  task automatic read_access(input axil_addr_t addr, output axil_data_t data);
    logic ar_hs;
    int   gap;
    gap = int'($urandom_range(0, 3));
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    do begin
      @(negedge clk_main_a0);
      ar_hs = arready;
      @(posedge clk_main_a0);
    end while (!ar_hs);
    arvalid <= 1'b0;
    do begin
      @(negedge clk_main_a0);
    end while (!rvalid);
    data = rdata;
    repeat (gap) begin
      @(negedge clk_main_a0);
      check_value(32'(rvalid), 32'd1, "rvalid dropped while rready was low");
      check_value(rdata, data, "rdata changed while rready was low");
    end
    @(posedge clk_main_a0);
    rready <= 1'b1;
    @(negedge clk_main_a0);
    check_value(32'(rresp), 32'(`AXI_RESP_OKAY), "read response code");
    @(posedge clk_main_a0);
    rready <= 1'b0;
  endtask

  task automatic run_counter(input entry_t e);
    int k;
    k = int'(e.addr[23:8]);
    @(posedge clk_main_a0);
    cnt_clear      <= 1'b1;
    tick_value     <= e.addr[7:0];
    cnt_load_value <= e.data[15:0];
    cnt_watermark  <= e.data[31:16];
    @(posedge clk_main_a0);
    cnt_clear <= 1'b0;
    cnt_load  <= 1'b1;
    @(posedge clk_main_a0);
    cnt_load <= 1'b0;
    // Enable window spans k edges and the last one drops it
    for (int i = 0; i < k; i++) begin
      @(posedge clk_main_a0);
      cnt_enable <= (i != k - 1);
    end
    repeat (2) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    check_value(32'(cnt), 32'(e.expected[15:0]), "counter value");
    check_value(32'(cnt_ge_watermark), 32'(e.expected[16]), "watermark flag");
    check_value(32'(tick_cnt), 32'(e.expected[24:17]), "prescaler count");
    check_value(32'(tick), 32'(e.expected[25]), "tick flag");
  endtask

  task automatic apply_entry(input entry_t e);
    axil_data_t rd;
    case (e.kind)
      OP_WRITE: write_access(e.addr, e.data);
      OP_READ: begin
        read_access(e.addr, rd);
        check_value(rd, e.expected, "read data");
      end
      OP_LED: begin
        @(posedge clk_main_a0);
        vdip <= e.expected[31:16];
        write_access(e.addr, e.data);
        repeat (4) @(posedge clk_main_a0);
        @(negedge clk_main_a0);
        check_value(32'(vled), 32'(e.expected[15:0]), "masked LED output");
      end
      default: run_counter(e);
    endcase
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int seed_ret;
    seed_ret = $urandom(32'hcc8e);
    rst_main_n_sync <= 1'b0;
    awvalid         <= 1'b0;
    awaddr          <= '0;
    wvalid          <= 1'b0;
    wdata           <= '0;
    bready          <= 1'b0;
    arvalid         <= 1'b0;
    araddr          <= '0;
    rready          <= 1'b0;
    vdip            <= '0;
    cnt_enable      <= 1'b0;
    cnt_load        <= 1'b0;
    cnt_clear       <= 1'b0;
    tick_value      <= '0;
    cnt_load_value  <= '0;
    cnt_watermark   <= '0;
    build_table();
    cycle_limit = 40 * stim.size() + run_len + 8;
    repeat (8) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(negedge clk_main_a0);
    check_value(32'({awready, arready, bvalid, rvalid}), 32'hc, "handshake state after reset");
    check_value(32'(vled), 32'd0, "vled after reset");
    check_value(32'(cnt), 32'd0, "counter after reset");
    check_value(32'({tick, cnt_ge_watermark, tick_cnt}), 32'd0, "counter status after reset");
    foreach (stim[i])
      apply_entry(stim[i]);
    repeat (2) @(posedge clk_main_a0);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: hello_world_reg.sv
`include "cl_hello_world_consts.svh"

module hello_world_reg (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  input  logic                          reg_wr,
  input  cl_hello_world_pkg::axil_addr_t reg_wr_addr,
  input  cl_hello_world_pkg::axil_data_t reg_wr_data,
  output cl_hello_world_pkg::axil_data_t hello_q
);

  logic hello_we;

  // Writes to other addresses are dropped here
  assign hello_we = reg_wr && (reg_wr_addr == `HELLO_WORLD_REG_ADDR);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (hello_we) begin
      hello_q <= reg_wr_data;
    end
  end

  hello_only_on_write: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !reg_wr |=> $stable(hello_q))
    else $error("hello register changed without a write strobe");

endmodule

// File: ocl_axil_slave.sv
`include "cl_hello_world_consts.svh"

module ocl_axil_slave (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  // Write address channel
  input  logic                          awvalid,
  input  cl_hello_world_pkg::axil_addr_t awaddr,
  output logic                          awready,
  // Write data channel
  input  logic                          wvalid,
  input  cl_hello_world_pkg::axil_data_t wdata,
  output logic                          wready,
  // Write response channel
  output logic                          bvalid,
  output cl_hello_world_pkg::axil_resp_t bresp,
  input  logic                          bready,
  // Read address channel
  input  logic                          arvalid,
  input  cl_hello_world_pkg::axil_addr_t araddr,
  output logic                          arready,
  // Read data channel
  output logic                          rvalid,
  output cl_hello_world_pkg::axil_data_t rdata,
  output cl_hello_world_pkg::axil_resp_t rresp,
  input  logic                          rready,
  // Register side
  input  cl_hello_world_pkg::axil_data_t hello_q,
  input  cl_hello_world_pkg::led_vec_t   vled_q,
  output logic                          reg_wr,
  output cl_hello_world_pkg::axil_addr_t reg_wr_addr,
  output cl_hello_world_pkg::axil_data_t reg_wr_data
);
  import cl_hello_world_pkg::*;

  wr_state_t  wr_state;
  axil_addr_t wr_addr_q;
  rd_state_t  rd_state;
  axil_addr_t rd_addr_q;
  axil_data_t rd_mux;

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:
          if (awvalid)
            wr_state <= WR_DATA;
        WR_DATA:
          if (wvalid)
            wr_state <= WR_RESP;
        WR_RESP:
          if (bready)
            wr_state <= WR_IDLE;
        default:
          wr_state <= WR_IDLE;
      endcase
    end
  end

  // Address is held for the whole data phase
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  assign awready = (wr_state == WR_IDLE);
  assign wready  = (wr_state == WR_DATA) && wvalid;
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = `AXI_RESP_OKAY;

  // One-cycle write pulse on the data handshake
  assign reg_wr      = wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE:
          if (arvalid)
            rd_state <= RD_DECODE;
        RD_DECODE:
          rd_state <= RD_RESP;
        RD_RESP:
          if (rready)
            rd_state <= RD_IDLE;
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  // Hello value reads back byte-reversed
  always_comb begin
    case (rd_addr_q)
      `HELLO_WORLD_REG_ADDR: rd_mux = {hello_q[7:0], hello_q[15:8],
                                       hello_q[23:16], hello_q[31:24]};
      `VLED_REG_ADDR:        rd_mux = {16'h0000, vled_q};
      default:               rd_mux = `UNIMPLEMENTED_REG_VALUE;
    endcase
  end

  // Data loads once at the end of decode and then holds
  always_ff @(posedge clk_main_a0) begin
    if (rd_state == RD_DECODE) begin
      rdata <= rd_mux;
    end
  end

  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);
  assign rresp   = `AXI_RESP_OKAY;

  // ------------------------------------------------------------
  // Handshake checks
  // ------------------------------------------------------------
  bvalid_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rdata_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rdata changed while rvalid was stalled");

endmodule

// File: tick_counter.sv
module tick_counter (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       cnt_enable,
  input  logic                       cnt_load,
  input  logic                       cnt_clear,
  input  cl_hello_world_pkg::tick_t  tick_value,
  input  cl_hello_world_pkg::count_t cnt_load_value,
  input  cl_hello_world_pkg::count_t cnt_watermark,
  output logic                       tick,
  output logic                       cnt_ge_watermark,
  output cl_hello_world_pkg::tick_t  tick_cnt,
  output cl_hello_world_pkg::count_t cnt
);
  import cl_hello_world_pkg::*;

  logic   cnt_enable_q;
  logic   cnt_load_q;
  logic   cnt_clear_q;
  tick_t  tick_value_q;
  count_t cnt_load_value_q;
  count_t cnt_watermark_q;
  logic   wrap;
  tick_t  tick_cnt_nxt;
  count_t cnt_nxt;

  // Input stage for all controls
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_enable_q     <= 1'b0;
      cnt_load_q       <= 1'b0;
      cnt_clear_q      <= 1'b0;
      tick_value_q     <= '0;
      cnt_load_value_q <= '0;
      cnt_watermark_q  <= '0;
    end else begin
      cnt_enable_q     <= cnt_enable;
      cnt_load_q       <= cnt_load;
      cnt_clear_q      <= cnt_clear;
      tick_value_q     <= tick_value;
      cnt_load_value_q <= cnt_load_value;
      cnt_watermark_q  <= cnt_watermark;
    end
  end

  // ------------------------------------------------------------
  // Prescaler and main counter
  // ------------------------------------------------------------
  assign wrap = cnt_enable_q && (tick_cnt >= tick_value_q);

  always_comb begin
    tick_cnt_nxt = tick_cnt;
    cnt_nxt      = cnt;
    if (cnt_clear_q) begin
      tick_cnt_nxt = '0;
      cnt_nxt      = '0;
    end else begin
      if (cnt_enable_q)
        tick_cnt_nxt = wrap ? tick_t'(0) : tick_t'(tick_cnt + 1'b1);
      // Load wins over the wrap increment
      if (cnt_load_q)
        cnt_nxt = cnt_load_value_q;
      else if (wrap)
        cnt_nxt = cnt + 1'b1;
    end
  end

  // Flags follow the updated counts at the same edge
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt         <= '0;
      cnt              <= '0;
      tick             <= 1'b0;
      cnt_ge_watermark <= 1'b0;
    end else begin
      tick_cnt         <= tick_cnt_nxt;
      cnt              <= cnt_nxt;
      tick             <= (tick_cnt_nxt >= tick_value_q);
      cnt_ge_watermark <= (cnt_nxt >= cnt_watermark_q);
    end
  end

  tick_cnt_bounded: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (cnt_enable_q || cnt_clear_q) ##1 $stable(tick_value_q) |-> tick_cnt <= tick_value_q)
    else $error("prescaler count ran past tick_value");

endmodule

// File: vled_shadow.sv
module vled_shadow (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  input  cl_hello_world_pkg::axil_data_t hello_q,
  input  cl_hello_world_pkg::led_vec_t   vdip,
  output cl_hello_world_pkg::led_vec_t   vled_q,
  output cl_hello_world_pkg::led_vec_t   vled
);
  import cl_hello_world_pkg::*;

  led_vec_t vdip_q1;
  led_vec_t vdip_q2;

  // ------------------------------------------------------------
  // LED shadow of the hello register low half
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_q[15:0];
    end
  end

  // ------------------------------------------------------------
  // DIP switch synchronizer and masked LED output
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  // Switches act as a per-bit enable on the LEDs
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= vled_q & vdip_q2;
    end
  end

endmodule
